/* flist.f */
logic/rv_isa_pkg.sv
logic/rv_mem_stage_pkg.sv
logic/store_format.sv
logic/load_format.sv
logic/dmem_access.sv
logic/branch_resolve.sv
logic/mem_wb_reg.sv
logic/mem_stage.sv
tests/mem_stage_tb.sv

/* tests/mem_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage_tb import rv_isa_pkg::*, rv_mem_stage_pkg::*;;

  localparam int RST_CYCLES     = 2;
  localparam int NUM_CYCLES     = 3000;
  localparam int TAIL_CYCLES    = 4;
  localparam int TIMEOUT_CYCLES = 4 * (RST_CYCLES + NUM_CYCLES + TAIL_CYCLES);

  // Legal size codes, first three also serve stores
  localparam funct3_t SIZE_CODES [5] = '{FUNCT3_B, FUNCT3_H, FUNCT3_W, FUNCT3_BU, FUNCT3_HU};

  logic clk;
  logic rst_n;
  logic valid_i;
  logic stall_i;
  ex_mem_t ex_drv;
  branch_info_t br_drv;
  word_t dmem_rdata;
  dmem_req_t dmem_o;
  redirect_t redir_o;
  word_t result_mem_o;
  word_t ld_data_mem_o;
  logic valid_o;
  mem_wb_t wb_o;

  int err_cnt = 0;
  int cycle_cnt = 0;
  int n_store = 0;
  int n_load = 0;
  int n_misalign = 0;
  int n_redir = 0;
  int n_stall = 0;

  mem_stage #(
    .PIPELINED(1),
    .BPRED_EN (1)
  ) i_mem_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .stall_i      (stall_i),
    .ex_i         (ex_drv),
    .br_i         (br_drv),
    .dmem_rdata_i (dmem_rdata),
    .dmem_o       (dmem_o),
    .redir_o      (redir_o),
    .result_mem_o (result_mem_o),
    .ld_data_mem_o(ld_data_mem_o),
    .valid_o      (valid_o),
    .wb_o         (wb_o)
  );

  // ==============================
  // Reference rules
  // ==============================

  function automatic logic is_misaligned(ex_mem_t ex);
    if (!(ex.mem_read || ex.mem_write)) return 1'b0;
    case (ex.funct3)
      FUNCT3_H, FUNCT3_HU: return ex.alu_result[0];
      FUNCT3_W:            return ex.alu_result[1:0] != 2'b00;
      default:             return 1'b0;
    endcase
  endfunction

  // Byte k of the bus gets the store data byte it could land on
  function automatic word_t store_lanes(word_t data, funct3_t f3);
    word_t lanes;
    int k;
    for (k = 0; k < 4; k++) begin
      case (f3)
        FUNCT3_B: lanes[8*k +: 8] = data[7:0];
        FUNCT3_H: lanes[8*k +: 8] = data[8*(k%2) +: 8];
        default:  lanes[8*k +: 8] = data[8*k +: 8];
      endcase
    end
    return lanes;
  endfunction

  function automatic logic [3:0] store_strobe(logic [1:0] lo, funct3_t f3);
    logic [3:0] strb;
    int k;
    for (k = 0; k < 4; k++) begin
      case (f3)
        FUNCT3_B: strb[k] = (k == int'(lo));
        FUNCT3_H: strb[k] = ((k / 2) == int'(lo[1]));
        default:  strb[k] = 1'b1;
      endcase
    end
    return strb;
  endfunction

  // Shift the addressed lane down, then extend
  function automatic word_t load_value(word_t rdata, logic [1:0] lo, funct3_t f3);
    word_t sh;
    sh = rdata >> {lo, 3'b000};
    case (f3)
      FUNCT3_B:  return {{24{sh[7]}}, sh[7:0]};
      FUNCT3_H:  return {{16{sh[15]}}, sh[15:0]};
      FUNCT3_BU: return {24'd0, sh[7:0]};
      FUNCT3_HU: return {16'd0, sh[15:0]};
      default:   return rdata;
    endcase
  endfunction

  function automatic word_t forward_value(ex_mem_t ex);
    case (ex.res_src)
      RES_M:   return ex.m_result;
      RES_PC4: return ex.pc_plus4;
      RES_TGT: return ex.jb_tgt;
      default: return ex.alu_result;
    endcase
  endfunction

  function automatic logic is_mispredicted(branch_info_t br, word_t tgt);
    if (br.is_branch) return br.branch_taken != br.bpred_taken;
    if (br.is_jalr) return !br.bpred_taken || (br.pred_tgt != tgt);
    return 1'b0;
  endfunction

  logic exp_misalign;
  logic exp_trap;
  trap_code_t exp_code;
  logic exp_we;
  logic exp_ren;
  word_t word_addr;
  word_t exp_wdata;
  logic [3:0] exp_wstrb;
  word_t exp_ld;
  word_t exp_fwd;
  logic exp_redir;
  word_t exp_tgt;

  assign exp_misalign = is_misaligned(ex_drv);
  assign exp_trap     = ex_drv.trap || exp_misalign;
  assign exp_code     = exp_misalign ? TRAP_LDST_MISALIGN : ex_drv.trap_code;
  assign exp_we       = valid_i && ex_drv.mem_write && !exp_trap;
  assign exp_ren      = valid_i && ex_drv.mem_read && !exp_trap;
  assign word_addr    = {ex_drv.alu_result[31:2], 2'b00};
  assign exp_wdata    = store_lanes(ex_drv.rs2_data, ex_drv.funct3);
  // Only stores drive byte strobes
  assign exp_wstrb    = ex_drv.mem_write ?
                        store_strobe(ex_drv.alu_result[1:0], ex_drv.funct3) : 4'b0000;
  assign exp_ld       = load_value(dmem_rdata, ex_drv.alu_result[1:0], ex_drv.funct3);
  assign exp_fwd      = forward_value(ex_drv);
  assign exp_redir    = valid_i && is_mispredicted(br_drv, ex_drv.jb_tgt);
  // Fall-through only for a branch predicted taken that was not taken
  assign exp_tgt = (br_drv.is_branch && br_drv.bpred_taken && !br_drv.branch_taken) ?
                   ex_drv.pc_plus4 : ex_drv.jb_tgt;

  // ==============================
  // WB register model
  // ==============================

  logic mdl_valid;
  logic mdl_reg_write;
  logic mdl_trap;
  trap_code_t mdl_code;
  word_t mdl_ld;
  logic mdl_ld_chk;
  // Payload fields pass from EX to WB unchanged
  ex_mem_t mdl_ex;
  logic mdl_pay_chk;

  always @(posedge clk) begin
    if (!rst_n) begin
      mdl_valid     <= 1'b0;
      mdl_reg_write <= 1'b0;
      mdl_trap      <= 1'b0;
      mdl_ld_chk    <= 1'b0;
      mdl_pay_chk   <= 1'b0;
    end else begin
      if (!stall_i) begin
        mdl_valid     <= valid_i;
        mdl_reg_write <= valid_i && ex_drv.reg_write && !exp_trap;
        mdl_trap      <= valid_i && exp_trap;
        mdl_code      <= exp_code;
        // Payload goes stale across bubbles
        if (valid_i) begin
          mdl_ld      <= exp_ld;
          mdl_ld_chk  <= exp_ren;
          mdl_ex      <= ex_drv;
          mdl_pay_chk <= 1'b1;
        end
      end
      if (exp_we) n_store <= n_store + 1;
      if (exp_ren) n_load <= n_load + 1;
      if (valid_i && exp_misalign) n_misalign <= n_misalign + 1;
      if (exp_redir) n_redir <= n_redir + 1;
      if (stall_i) n_stall <= n_stall + 1;
    end
  end

  // ==============================
  // Checkers
  // ==============================

  task automatic report_mismatch(input string test_name, input word_t expected,
                                 input word_t actual);
    err_cnt++;
    $display("ERROR %s: expected %h actual %h", test_name, expected, actual);
  endtask

  a_store_we: assert property (@(posedge clk) disable iff (!rst_n) dmem_o.we == exp_we)
    else report_mismatch("store we", 32'($sampled(exp_we)), 32'($sampled(dmem_o.we)));
  a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
    exp_we |-> dmem_o.waddr == word_addr)
    else report_mismatch("store waddr", $sampled(word_addr), $sampled(dmem_o.waddr));
  a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
    exp_we |-> dmem_o.wdata == exp_wdata)
    else report_mismatch("store wdata", $sampled(exp_wdata), $sampled(dmem_o.wdata));
  a_store_strb: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_o.wstrb == exp_wstrb)
    else report_mismatch("store wstrb", 32'($sampled(exp_wstrb)),
                         32'($sampled(dmem_o.wstrb)));
  a_load_ren: assert property (@(posedge clk) disable iff (!rst_n) dmem_o.ren == exp_ren)
    else report_mismatch("load ren", 32'($sampled(exp_ren)), 32'($sampled(dmem_o.ren)));
  a_load_addr: assert property (@(posedge clk) disable iff (!rst_n)
    exp_ren |-> dmem_o.raddr == word_addr)
    else report_mismatch("load raddr", $sampled(word_addr), $sampled(dmem_o.raddr));
  a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
    exp_ren |-> ld_data_mem_o == exp_ld)
    else report_mismatch("load data", $sampled(exp_ld), $sampled(ld_data_mem_o));
  a_forward: assert property (@(posedge clk) disable iff (!rst_n) result_mem_o == exp_fwd)
    else report_mismatch("forward result", $sampled(exp_fwd), $sampled(result_mem_o));
  a_redir_valid: assert property (@(posedge clk) disable iff (!rst_n)
    redir_o.valid == exp_redir)
    else report_mismatch("redirect valid", 32'($sampled(exp_redir)),
                         32'($sampled(redir_o.valid)));
  a_redir_tgt: assert property (@(posedge clk) disable iff (!rst_n)
    exp_redir |-> redir_o.tgt == exp_tgt)
    else report_mismatch("redirect target", $sampled(exp_tgt), $sampled(redir_o.tgt));
  a_wb_valid: assert property (@(posedge clk) disable iff (!rst_n) valid_o == mdl_valid)
    else report_mismatch("wb valid", 32'($sampled(mdl_valid)), 32'($sampled(valid_o)));
  a_wb_reg_write: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.reg_write == mdl_reg_write)
    else report_mismatch("wb reg_write", 32'($sampled(mdl_reg_write)),
                         32'($sampled(wb_o.reg_write)));
  a_wb_trap: assert property (@(posedge clk) disable iff (!rst_n) wb_o.trap == mdl_trap)
    else report_mismatch("wb trap", 32'($sampled(mdl_trap)), 32'($sampled(wb_o.trap)));
  a_wb_code: assert property (@(posedge clk) disable iff (!rst_n)
    mdl_trap |-> wb_o.trap_code == mdl_code)
    else report_mismatch("wb trap_code", 32'($sampled(mdl_code)),
                         32'($sampled(wb_o.trap_code)));
  a_wb_ld: assert property (@(posedge clk) disable iff (!rst_n)
    mdl_ld_chk |-> wb_o.ld_data == mdl_ld)
    else report_mismatch("wb ld_data", $sampled(mdl_ld), $sampled(wb_o.ld_data));

  // Tag fields packed as res_src, rd, funct3
  a_wb_tags: assert property (@(posedge clk) disable iff (!rst_n)
    mdl_pay_chk |-> {wb_o.res_src, wb_o.rd, wb_o.funct3} ==
                    {mdl_ex.res_src, mdl_ex.rd, mdl_ex.funct3})
    else report_mismatch("wb tags",
                         32'($sampled({mdl_ex.res_src, mdl_ex.rd, mdl_ex.funct3})),
                         32'($sampled({wb_o.res_src, wb_o.rd, wb_o.funct3})));
  a_wb_alu: assert property (@(posedge clk) disable iff (!rst_n)
    mdl_pay_chk |-> wb_o.alu_result == mdl_ex.alu_result)
    else report_mismatch("wb alu_result", $sampled(mdl_ex.alu_result),
                         $sampled(wb_o.alu_result));
  a_wb_pc4: assert property (@(posedge clk) disable iff (!rst_n)
    mdl_pay_chk |-> wb_o.pc_plus4 == mdl_ex.pc_plus4)
    else report_mismatch("wb pc_plus4", $sampled(mdl_ex.pc_plus4),
                         $sampled(wb_o.pc_plus4));
  a_wb_tgt: assert property (@(posedge clk) disable iff (!rst_n)
    mdl_pay_chk |-> wb_o.jb_tgt == mdl_ex.jb_tgt)
    else report_mismatch("wb jb_tgt", $sampled(mdl_ex.jb_tgt), $sampled(wb_o.jb_tgt));
  a_wb_m: assert property (@(posedge clk) disable iff (!rst_n)
    mdl_pay_chk |-> wb_o.m_result == mdl_ex.m_result)
    else report_mismatch("wb m_result", $sampled(mdl_ex.m_result),
                         $sampled(wb_o.m_result));

  // ==============================
  // Stimulus
  // ==============================

  // Low address bits, aligned or misaligned on request
  function automatic logic [1:0] pick_offset(funct3_t f3, logic misalign);
    logic [1:0] lo;
    lo = 2'($urandom);
    if (f3 == FUNCT3_W) begin
      lo = misalign ? ((lo == 2'd0) ? 2'd1 : lo) : 2'd0;
    end else if (f3 == FUNCT3_H || f3 == FUNCT3_HU) begin
      lo[0] = misalign;
    end
    return lo;
  endfunction

  task automatic drive_random();
    int unsigned kind;
    logic want_misalign;
    kind          = $urandom_range(0, 4);
    want_misalign = ($urandom_range(0, 3) == 0);
    valid_i       = ($urandom_range(0, 7) != 0);
    stall_i       = ($urandom_range(0, 4) == 0);
    dmem_rdata    = $urandom;
    ex_drv        = '0;
    br_drv        = '0;
    ex_drv.reg_write  = 1'($urandom);
    ex_drv.res_src    = res_src_e'($urandom_range(0, 4));
    ex_drv.rd         = 5'($urandom);
    ex_drv.funct3     = 3'($urandom);
    ex_drv.alu_result = $urandom;
    ex_drv.rs2_data   = $urandom;
    ex_drv.pc_plus4   = $urandom;
    ex_drv.jb_tgt     = $urandom;
    ex_drv.m_result   = $urandom;
    // Rare trap from an earlier stage
    ex_drv.trap       = ($urandom_range(0, 15) == 0);
    ex_drv.trap_code  = 2'($urandom);
    case (kind)
      1: begin
        ex_drv.mem_read  = 1'b1;
        ex_drv.reg_write = 1'b1;
        ex_drv.res_src   = RES_MEM;
        ex_drv.funct3    = SIZE_CODES[$urandom_range(0, 4)];
      end
      2: begin
        ex_drv.mem_write = 1'b1;
        ex_drv.reg_write = 1'b0;
        ex_drv.funct3    = SIZE_CODES[$urandom_range(0, 2)];
      end
      3: begin
        br_drv.is_branch    = 1'b1;
        br_drv.branch_taken = 1'($urandom);
        br_drv.bpred_taken  = 1'($urandom);
        br_drv.pred_tgt     = $urandom;
      end
      4: begin
        br_drv.is_jalr     = 1'b1;
        br_drv.bpred_taken = 1'($urandom);
        // Half the time the predictor had the right target
        br_drv.pred_tgt    = $urandom_range(0, 1) ? ex_drv.jb_tgt : $urandom;
        ex_drv.res_src     = RES_PC4;
      end
      default: ;
    endcase
    ex_drv.alu_result[1:0] = pick_offset(ex_drv.funct3, want_misalign);
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Hard stop if the run never reaches its report
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(75));
    rst_n      = 1'b0;
    valid_i    = 1'b0;
    stall_i    = 1'b0;
    ex_drv     = '0;
    br_drv     = '0;
    dmem_rdata = '0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (NUM_CYCLES) begin
      drive_random();
      @(negedge clk);
    end
    // Drain the WB register
    valid_i = 1'b0;
    stall_i = 1'b0;
    repeat (TAIL_CYCLES) @(negedge clk);
    $display("%0d cycles %0d stores %0d loads %0d misaligned %0d redirects %0d stalls %0d errors",
             NUM_CYCLES, n_store, n_load, n_misalign, n_redir, n_stall, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

// Memory-access stage of the in-order core
module mem_stage import rv_isa_pkg::*, rv_mem_stage_pkg::*; #(
  parameter int PIPELINED = 1,
  parameter int BPRED_EN  = 1
) (
  input  wire logic         clk,
  input  wire logic         rst_n,
  // From EX
  input  wire logic         valid_i,
  input  wire logic         stall_i,
  input  wire ex_mem_t      ex_i,
  input  wire branch_info_t br_i,
  // Data memory, combinational read
  input  wire word_t        dmem_rdata_i,
  output dmem_req_t         dmem_o,
  // To fetch
  output redirect_t         redir_o,
  // Forwarding
  output word_t             result_mem_o,
  output word_t             ld_data_mem_o,
  // To WB
  output logic              valid_o,
  output mem_wb_t           wb_o
);

  logic       mem_trap;
  trap_code_t mem_trap_code;
  word_t      ld_data;
  mem_wb_t    wb_in;

  // ==============================
  // Memory access
  // ==============================

  dmem_access i_dmem_access (
    .valid_i    (valid_i),
    .ex_i       (ex_i),
    .dmem_o     (dmem_o),
    .trap_o     (mem_trap),
    .trap_code_o(mem_trap_code)
  );

  // Read data returns in the same cycle
  load_format i_load_format (
    .rdata_i  (dmem_rdata_i),
    .addr_lo_i(ex_i.alu_result[1:0]),
    .funct3_i (ex_i.funct3),
    .data_o   (ld_data)
  );

  assign ld_data_mem_o = ld_data;

  // Control flow check
  branch_resolve #(
    .BPRED_EN(BPRED_EN)
  ) i_branch_resolve (
    .valid_i   (valid_i),
    .br_i      (br_i),
    .jb_tgt_i  (ex_i.jb_tgt),
    .pc_plus4_i(ex_i.pc_plus4),
    .redir_o   (redir_o)
  );

  // ==============================
  // Forwarding and WB
  // ==============================

  // Load results forward through ld_data_mem_o instead
  always_comb begin
    case (ex_i.res_src)
      RES_M:   result_mem_o = ex_i.m_result;
      RES_PC4: result_mem_o = ex_i.pc_plus4;
      RES_TGT: result_mem_o = ex_i.jb_tgt;
      default: result_mem_o = ex_i.alu_result;
    endcase
  end

  // A trapping instruction must not write the register file
  always_comb begin
    wb_in.reg_write  = ex_i.reg_write && !mem_trap;
    wb_in.trap       = mem_trap;
    wb_in.trap_code  = mem_trap_code;
    wb_in.res_src    = ex_i.res_src;
    wb_in.rd         = ex_i.rd;
    wb_in.funct3     = ex_i.funct3;
    wb_in.alu_result = ex_i.alu_result;
    wb_in.ld_data    = ld_data;
    wb_in.pc_plus4   = ex_i.pc_plus4;
    wb_in.jb_tgt     = ex_i.jb_tgt;
    wb_in.m_result   = ex_i.m_result;
  end

  mem_wb_reg #(
    .PIPELINED(PIPELINED)
  ) i_mem_wb_reg (
    .clk    (clk),
    .rst_n  (rst_n),
    .valid_i(valid_i),
    .stall_i(stall_i),
    .wb_i   (wb_in),
    .valid_o(valid_o),
    .wb_o   (wb_o)
  );

  // A trap raised here arrives in WB on the next advance
  if (PIPELINED != 0) begin : g_trap_chk
    a_trap_to_wb: assert property (@(posedge clk) disable iff (!rst_n)
      (valid_i && !stall_i && mem_trap) |=> (valid_o && wb_o.trap && !wb_o.reg_write))
      else $error("mem_stage: trap did not reach WB");
  end

endmodule

`default_nettype wire

/* logic/mem_wb_reg.sv */
`timescale 1ns/1ns
`default_nettype none

// MEM/WB pipeline register
module mem_wb_reg import rv_isa_pkg::*, rv_mem_stage_pkg::*; #(
  parameter int PIPELINED = 1
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    valid_i,
  input  wire logic    stall_i,
  input  wire mem_wb_t wb_i,
  output logic         valid_o,
  output mem_wb_t      wb_o
);

  if (PIPELINED != 0) begin : g_reg

    logic    valid_q;
    logic    reg_write_q;
    logic    trap_q;
    mem_wb_t payload_q;

    // ==============================
    // Control bits
    // ==============================

    // Cleared on a bubble so WB acts on them without checking valid
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q     <= 1'b0;
        reg_write_q <= 1'b0;
        trap_q      <= 1'b0;
      end else if (!stall_i) begin
        valid_q     <= valid_i;
        reg_write_q <= valid_i && wb_i.reg_write;
        trap_q      <= valid_i && wb_i.trap;
      end
    end

    // ==============================
    // Payload
    // ==============================

    // Loads only with a valid instruction, goes stale across bubbles
    always_ff @(posedge clk) begin
      if (!stall_i && valid_i) begin
        payload_q <= wb_i;
      end
    end

    assign valid_o = valid_q;

    // Control bits override the payload copies
    always_comb begin
      wb_o           = payload_q;
      wb_o.reg_write = reg_write_q;
      wb_o.trap      = trap_q;
    end

    // A stalled instruction in WB is never lost
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (stall_i && valid_o) |=> valid_o)
      else $error("mem_wb_reg: valid_o dropped under stall");

  end else begin : g_pass

    // Same-cycle pass-through, bubble still clears control
    assign valid_o = valid_i;

    always_comb begin
      wb_o           = wb_i;
      wb_o.reg_write = valid_i && wb_i.reg_write;
      wb_o.trap      = valid_i && wb_i.trap;
    end

  end

endmodule

`default_nettype wire

/* logic/branch_resolve.sv */
`timescale 1ns/1ns
`default_nettype none

// Branch and JALR misprediction check with PC redirect
module branch_resolve import rv_isa_pkg::*, rv_mem_stage_pkg::*; #(
  parameter int BPRED_EN = 1
) (
  input  wire logic         valid_i,
  input  wire branch_info_t br_i,
  input  wire word_t        jb_tgt_i,
  input  wire word_t        pc_plus4_i,
  output redirect_t         redir_o
);

  logic pred_taken;
  logic branch_mispred;
  logic jalr_mispred;
  logic pred_taken_not;

  // Without a predictor fetch always falls through
  assign pred_taken = (BPRED_EN != 0) ? br_i.bpred_taken : 1'b0;

  // ==============================
  // Misprediction
  // ==============================

  // Conditional branch went the other way
  assign branch_mispred = br_i.is_branch && (br_i.branch_taken != pred_taken);

  // JALR always jumps
  // wrong when fetch did not follow or followed to the wrong address
  assign jalr_mispred = br_i.is_jalr &&
                        (!pred_taken || (br_i.pred_tgt != jb_tgt_i));

  // ==============================
  // Redirect
  // ==============================

  // Fetch went to the target but the branch fell through
  assign pred_taken_not = branch_mispred && !br_i.branch_taken;

  always_comb begin
    redir_o.valid = valid_i && (branch_mispred || jalr_mispred);
    if (pred_taken_not) begin
      redir_o.tgt = pc_plus4_i;
    end else begin
      redir_o.tgt = jb_tgt_i;
    end
  end

  // Only control transfers may steer fetch
  a_redir_src: assert final (!redir_o.valid || br_i.is_branch || br_i.is_jalr)
    else $error("branch_resolve: redirect without branch or jalr");

endmodule

`default_nettype wire

/* logic/dmem_access.sv */
`timescale 1ns/1ns
`default_nettype none

// Misalignment check and data memory request
module dmem_access import rv_isa_pkg::*, rv_mem_stage_pkg::*; (
  input  wire logic    valid_i,
  input  wire ex_mem_t ex_i,
  output dmem_req_t    dmem_o,
  output logic         trap_o,
  output trap_code_t   trap_code_o
);

  logic       misalign;
  word_t      st_wdata;
  logic [3:0] st_wstrb;

  // Store lanes and strobes from rs2 and the address
  store_format i_store_format (
    .addr_lo_i(ex_i.alu_result[1:0]),
    .data_i   (ex_i.rs2_data),
    .funct3_i (ex_i.funct3),
    .wdata_o  (st_wdata),
    .wstrb_o  (st_wstrb)
  );

  // ==============================
  // Misalignment trap
  // ==============================

  // Size is in the low two funct3 bits, byte accesses never misalign
  always_comb begin
    misalign = 1'b0;
    if (ex_i.mem_read || ex_i.mem_write) begin
      case (ex_i.funct3[1:0])
        FUNCT3_H[1:0]: misalign = ex_i.alu_result[0];
        FUNCT3_W[1:0]: misalign = |ex_i.alu_result[1:0];
        default:       misalign = 1'b0;
      endcase
    end
  end

  // Own misalignment wins over a trap from an earlier stage
  assign trap_o      = ex_i.trap || misalign;
  assign trap_code_o = misalign ? TRAP_LDST_MISALIGN : ex_i.trap_code;

  // ==============================
  // Memory request
  // ==============================

  // A trapped access never reaches memory
  always_comb begin
    dmem_o.ren   = valid_i && ex_i.mem_read && !trap_o;
    dmem_o.raddr = {ex_i.alu_result[31:2], 2'b00};
    dmem_o.we    = valid_i && ex_i.mem_write && !trap_o;
    dmem_o.waddr = {ex_i.alu_result[31:2], 2'b00};
    dmem_o.wdata = st_wdata;
    dmem_o.wstrb = ex_i.mem_write ? st_wstrb : 4'b0000;
  end

  // Decode in EX must never mark one instruction as load and store
  a_no_ren_we: assert final (!(dmem_o.ren && dmem_o.we))
    else $error("dmem_access: ren and we high together");

endmodule

`default_nettype wire

/* logic/load_format.sv */
`timescale 1ns/1ns
`default_nettype none

// Load data lane extraction and extension
module load_format import rv_isa_pkg::*; (
  input  wire word_t      rdata_i,
  input  wire logic [1:0] addr_lo_i,
  input  wire funct3_t    funct3_i,
  output word_t           data_o
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // ==============================
  // Lane select
  // ==============================

  // Byte lane by the two low address bits
  always_comb begin
    case (addr_lo_i)
      2'd0:    ld_byte = rdata_i[7:0];
      2'd1:    ld_byte = rdata_i[15:8];
      2'd2:    ld_byte = rdata_i[23:16];
      default: ld_byte = rdata_i[31:24];
    endcase
  end

  // Halfword lane by address bit 1
  // bit 0 is known clear, misaligned loads trap before this
  assign ld_half = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  // ==============================
  // Extension
  // ==============================

  always_comb begin
    case (funct3_i)
      // Signed forms replicate the top bit
      FUNCT3_B:  data_o = {{24{ld_byte[7]}}, ld_byte};
      FUNCT3_H:  data_o = {{16{ld_half[15]}}, ld_half};
      // Unsigned forms pad with zeros
      FUNCT3_BU: data_o = {24'd0, ld_byte};
      FUNCT3_HU: data_o = {16'd0, ld_half};
      // Word loads unchanged
      FUNCT3_W:  data_o = rdata_i;
      default:   data_o = rdata_i;
    endcase
  end

endmodule

`default_nettype wire

/* logic/store_format.sv */
`timescale 1ns/1ns
`default_nettype none

// Store data lane alignment and byte strobes
module store_format import rv_isa_pkg::*; (
  input  wire logic [1:0] addr_lo_i,
  input  wire word_t      data_i,
  input  wire funct3_t    funct3_i,
  output word_t           wdata_o,
  output logic [3:0]      wstrb_o
);

  // ==============================
  // Lane replication
  // ==============================

  // Memory picks the lane through the strobe
  // so the data is copied to every lane it could land on
  always_comb begin
    case (funct3_i)
      FUNCT3_B: begin
        wdata_o = {4{data_i[7:0]}};
      end
      FUNCT3_H: begin
        wdata_o = {2{data_i[15:0]}};
      end
      default: begin
        wdata_o = data_i;
      end
    endcase
  end

  // ==============================
  // Byte strobes
  // ==============================

  always_comb begin
    case (funct3_i)
      // One lane at the byte offset
      FUNCT3_B: wstrb_o = 4'b0001 << addr_lo_i;
      // Upper or lower half by address bit 1
      FUNCT3_H: wstrb_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
      // Full word
      default:  wstrb_o = 4'b1111;
    endcase
  end

endmodule

`default_nettype wire

/* logic/rv_mem_stage_pkg.sv */
`default_nettype none

// Bundles that cross the boundaries of the memory-access stage
package rv_mem_stage_pkg;

  import rv_isa_pkg::*;

  // ==============================
  // Stage inputs from EX
  // ==============================

  // Instruction state from the EX/MEM register
  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    res_src_e   res_src;
    reg_idx_t   rd;
    funct3_t    funct3;
    word_t      alu_result;  // also the load/store address
    word_t      rs2_data;
    word_t      pc_plus4;
    word_t      jb_tgt;
    word_t      m_result;
    logic       trap;
    trap_code_t trap_code;
  } ex_mem_t;

  // Branch outcome and what the fetch predictor assumed
  typedef struct packed {
    logic  is_branch;
    logic  is_jalr;
    logic  branch_taken;
    logic  bpred_taken;
    word_t pred_tgt;
  } branch_info_t;

  // ==============================
  // Stage outputs
  // ==============================

  // Data memory request, separate read and write ports
  typedef struct packed {
    logic       ren;
    word_t      raddr;
    logic       we;
    word_t      waddr;
    word_t      wdata;
    logic [3:0] wstrb;
  } dmem_req_t;

  // PC redirect, taken in the cycle it is raised
  typedef struct packed {
    logic  valid;
    word_t tgt;
  } redirect_t;

  // MEM/WB register contents
  typedef struct packed {
    logic       reg_write;
    logic       trap;
    trap_code_t trap_code;
    res_src_e   res_src;
    reg_idx_t   rd;
    funct3_t    funct3;
    word_t      alu_result;
    word_t      ld_data;
    word_t      pc_plus4;
    word_t      jb_tgt;
    word_t      m_result;
  } mem_wb_t;

endpackage

`default_nettype wire

/* logic/rv_isa_pkg.sv */
`default_nettype none

// Architectural types and codes of the RV32 base ISA
// Nothing here is specific to one pipeline stage
package rv_isa_pkg;

  // ==============================
  // Meaningful widths
  // ==============================

  // Data or address word
  typedef logic [31:0] word_t;

  // Register file index
  typedef logic [4:0] reg_idx_t;

  // funct3 field of the instruction word
  typedef logic [2:0] funct3_t;

  // ==============================
  // Load and store size codes
  // ==============================

  // Shared by loads and stores, loads sign-extend
  localparam funct3_t FUNCT3_B  = 3'd0;
  localparam funct3_t FUNCT3_H  = 3'd1;
  localparam funct3_t FUNCT3_W  = 3'd2;

  // Zero-extending loads only
  localparam funct3_t FUNCT3_BU = 3'd4;
  localparam funct3_t FUNCT3_HU = 3'd5;

  // ==============================
  // Result source and traps
  // ==============================

  // Which value the instruction writes back
  typedef enum logic [2:0] {
    RES_ALU = 3'd0,
    RES_MEM = 3'd1,
    RES_PC4 = 3'd2,  // link address of JAL and JALR
    RES_TGT = 3'd3,  // AUIPC result
    RES_M   = 3'd4
  } res_src_e;

  // Trap cause carried down the pipe
  typedef logic [1:0] trap_code_t;

  // Misaligned load or store address
  localparam trap_code_t TRAP_LDST_MISALIGN = 2'd2;

endpackage

`default_nettype wire
